// File: filelist.f
wr_gen_pkg.sv
wr_item_if.sv
wr_sequencer.sv
wr_addr_pattern_pipe.sv
wr_line_buffer.sv
wr_line_issue.sv
wr_gen_top.sv
tb_wr_gen.sv

// File: Bender.yml
package:
  name: wr_gen

sources:
  - wr_gen_pkg.sv
  - wr_item_if.sv
  - wr_sequencer.sv
  - wr_addr_pattern_pipe.sv
  - wr_line_buffer.sv
  - wr_line_issue.sv
  - wr_gen_top.sv
  - target: test
    files:
      - tb_wr_gen.sv

// File: tb_wr_gen.sv
module tb_wr_gen;
  timeunit 1ns;
  timeprecision 100ps;
  import wr_gen_pkg::*;

  logic     clk;
  logic     reset_n;
  logic     i_start;
  count_t   i_nai;
  pattern_t i_base_p;
  addr_t    i_base_x;
  incr_t    i_rai;
  psize_t   i_pattern_size;
  mask_t    i_byte_mask;
  logic     i_wr_ready;
  logic     o_busy;
  logic     o_wr_valid;
  addr_t    o_wr_addr;
  line_t    o_wr_data;
  mask_t    o_wr_strb;

  // configuration of the run in progress, which the model reads
  count_t   cfg_nai;
  pattern_t cfg_base_p;
  addr_t    cfg_base_x;
  incr_t    cfg_rai;
  psize_t   cfg_size;
  mask_t    cfg_mask;

  int       exp_n;
  int       wr_count;
  int       value_errors;
  int       other_errors;
  logic     hold_valid;
  addr_t    hold_addr;
  line_t    hold_data;
  mask_t    hold_strb;
  logic [15:0] lfsr_state;

  wr_gen_top dut0 (
    .clk(clk), .reset_n(reset_n), .i_start(i_start), .i_nai(i_nai),
    .i_base_p(i_base_p), .i_base_x(i_base_x), .i_rai(i_rai),
    .i_pattern_size(i_pattern_size), .i_byte_mask(i_byte_mask), .i_wr_ready(i_wr_ready),
    .o_busy(o_busy), .o_wr_valid(o_wr_valid), .o_wr_addr(o_wr_addr),
    .o_wr_data(o_wr_data), .o_wr_strb(o_wr_strb)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  // one step per bit, and the first bit taken ends up as the most significant one
  function automatic logic [63:0] lfsr_bits(input int width);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < width; i++)
      value = {value[62:0], lfsr_step()};
    return value;
  endfunction

  // item N is written to X plus N times RAI, wrapping at the address width
  function automatic addr_t expected_addr(input int n);
    return cfg_base_x + addr_t'(n) * addr_t'(cfg_rai);
  endfunction

  // P plus N cut to the selected number of bytes, while any other code gives a zero pattern
  function automatic pattern_t expected_pattern(input int n);
    pattern_t p;
    p = cfg_base_p + pattern_t'(n);
    case (cfg_size)
      3'd1:    return p & 32'h0000_00ff;
      3'd2:    return p & 32'h0000_ffff;
      3'd4:    return p;
      default: return '0;
    endcase
  endfunction

  // masked byte i of the line holds pattern byte i mod size
  function automatic line_t expected_line(input int n);
    pattern_t pat;
    line_t    line;
    int       size;
    pat  = expected_pattern(n);
    line = '0;
    case (cfg_size)
      3'd1:    size = 1;
      3'd2:    size = 2;
      3'd4:    size = 4;
      default: size = 0;
    endcase
    if (size != 0)
      for (int i = 0; i < LINE_BYTES; i++)
        if (cfg_mask[i])
          line[i*8 +: 8] = pat[(i % size)*8 +: 8];
    return line;
  endfunction

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_line(input string name, input line_t got, input line_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_strb(input string name, input mask_t got, input mask_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // the write port is sampled mid-cycle, where valid, ready and data are settled
  always @(negedge clk)
  begin
    // a write that was refused last cycle must be offered again unchanged
    if (hold_valid)
    begin
      compare_bit("o_wr_valid while not ready", o_wr_valid, 1'b1);
      compare_addr("o_wr_addr while not ready", o_wr_addr, hold_addr);
      compare_line("o_wr_data while not ready", o_wr_data, hold_data);
      compare_strb("o_wr_strb while not ready", o_wr_strb, hold_strb);
    end
    hold_valid = 1'b0;
    if (o_wr_valid === 1'b1 && i_wr_ready === 1'b1)
    begin
      if (exp_n >= int'(cfg_nai))
      begin
        other_errors++;
        $display("a write was accepted after all items of the run were written");
      end
      else
      begin
        compare_addr("o_wr_addr", o_wr_addr, expected_addr(exp_n));
        compare_line("o_wr_data", o_wr_data, expected_line(exp_n));
        compare_strb("o_wr_strb", o_wr_strb, cfg_mask);
      end
      exp_n++;
      wr_count++;
    end
    else if (o_wr_valid === 1'b1)
    begin
      hold_valid = 1'b1;
      hold_addr  = o_wr_addr;
      hold_data  = o_wr_data;
      hold_strb  = o_wr_strb;
    end
  end

  // loads the run configuration, gives a one-cycle start strobe and returns just after it
  task automatic begin_run(input count_t nai, input pattern_t base_p, input addr_t base_x,
                           input incr_t rai, input psize_t size, input mask_t mask);
    @(posedge clk);
    #1;
    cfg_nai        = nai;
    cfg_base_p     = base_p;
    cfg_base_x     = base_x;
    cfg_rai        = rai;
    cfg_size       = size;
    cfg_mask       = mask;
    exp_n          = 0;
    wr_count       = 0;
    i_nai          = nai;
    i_base_p       = base_p;
    i_base_x       = base_x;
    i_rai          = rai;
    i_pattern_size = size;
    i_byte_mask    = mask;
    i_start        = 1'b1;
    @(posedge clk);
    #1;
    i_start = 1'b0;
  endtask

  // gives a start strobe and leaves the run configuration as it is
  task automatic pulse_start();
    @(posedge clk);
    #1;
    i_start = 1'b1;
    @(posedge clk);
    #1;
    i_start = 1'b0;
  endtask

  // waits for the run to end, optionally stepping ready from the LFSR every cycle
  task automatic wait_idle(input int limit, input logic rand_ready);
    int cycles;
    cycles = 0;
    while (o_busy !== 1'b0 && cycles < limit)
    begin
      @(posedge clk);
      #1;
      if (rand_ready)
        i_wr_ready = lfsr_step();
      cycles++;
    end
    if (o_busy !== 1'b0)
    begin
      other_errors++;
      $display("timeout: o_busy still high after %0d cycles", limit);
    end
    i_wr_ready = 1'b1;
  endtask

  // busy may only fall once every item is accepted, and nothing may follow on the port
  task automatic check_run_end(input string name);
    compare_count({name, " writes when busy fell"}, count_t'(wr_count), cfg_nai);
    repeat (3) @(posedge clk);
    #1;
    compare_bit({name, " o_wr_valid after run"}, o_wr_valid, 1'b0);
    compare_count({name, " write count"}, count_t'(wr_count), cfg_nai);
  endtask

  task automatic reset_and_address_run();
    int cycles;
    compare_bit("o_busy after reset", o_busy, 1'b0);
    compare_bit("o_wr_valid after reset", o_wr_valid, 1'b0);
    begin_run(9'd8, 32'h1000_00fe, 52'h0_0012_3400_0000, 38'h00_0000_0040, 3'd4, '1);
    compare_bit("o_busy one edge after start", o_busy, 1'b1);
    // the first write appears a fixed four cycles after busy rises
    cycles = 0;
    while (o_wr_valid !== 1'b1 && cycles < 20)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (o_wr_valid !== 1'b1)
    begin
      other_errors++;
      $display("timeout: no write appeared after the start strobe");
    end
    else
      compare_count("first write latency", count_t'(cycles), 9'd4);
    wait_idle(200, 1'b0);
    check_run_end("reset test");
  endtask

  task automatic pattern_size_sweep();
    psize_t sizes [5];
    sizes = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd6};
    foreach (sizes[k])
    begin
      // sparse mask so that lane position and pattern byte index can be told apart
      begin_run(9'd6, 32'hA1B2_C3FD, 52'h0_0000_0800_0000, 38'h00_0000_1000, sizes[k],
                64'h8421_0F00_00F0_1356);
      wait_idle(200, 1'b0);
      check_run_end("pattern size test");
    end
  endtask

  task automatic back_pressure_stall();
    i_wr_ready = 1'b0;
    begin_run(9'd30, 32'h0000_7ff8, 52'h0_0000_0000_1000, 38'h00_0000_0080, 3'd2,
              64'h00ff_ff00_0f0f_f0f0);
    // the port stalls while the buffer fills up to the threshold
    repeat (40)
    begin
      @(posedge clk);
      #1;
      compare_bit("o_busy while stalled", o_busy, 1'b1);
    end
    compare_bit("o_wr_valid while stalled", o_wr_valid, 1'b1);
    compare_addr("o_wr_addr while stalled", o_wr_addr, expected_addr(0));
    i_wr_ready = 1'b1;
    wait_idle(400, 1'b0);
    check_run_end("back-pressure test");
  endtask

  task automatic random_ready_runs();
    count_t   nai;
    pattern_t base_p;
    addr_t    base_x;
    incr_t    rai;
    psize_t   size;
    mask_t    mask;
    repeat (3)
    begin
      nai    = count_t'(lfsr_bits(7)) + 9'd16;
      base_p = pattern_t'(lfsr_bits(32));
      base_x = addr_t'(lfsr_bits(52));
      rai    = incr_t'(lfsr_bits(38));
      size   = psize_t'(lfsr_bits(3));
      mask   = mask_t'(lfsr_bits(64));
      i_wr_ready = lfsr_step();
      begin_run(nai, base_p, base_x, rai, size, mask);
      wait_idle(3000, 1'b1);
      check_run_end("random ready test");
    end
  endtask

  task automatic ignored_start_and_empty_run();
    int cycles;
    begin_run(9'd20, 32'h5555_0000, 52'h0_0000_0010_0000, 38'h00_0000_0200, 3'd1,
              64'hffff_0000_ffff_0000);
    // strobe again once a few writes have gone out
    cycles = 0;
    while (wr_count < 5 && cycles < 100)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (wr_count < 5)
    begin
      other_errors++;
      $display("timeout: the run did not reach five writes");
    end
    pulse_start();
    wait_idle(300, 1'b0);
    check_run_end("start while busy test");
    repeat (10) @(posedge clk);
    #1;
    compare_bit("o_busy after ignored start", o_busy, 1'b0);
    // an empty run still passes through busy but writes nothing
    begin_run(9'd0, 32'h0, 52'h0, 38'h0, 3'd4, '1);
    compare_bit("o_busy in empty run", o_busy, 1'b1);
    wait_idle(50, 1'b0);
    check_run_end("empty run test");
  endtask

  initial
  begin
    lfsr_state     = 16'd23185;
    reset_n        = 1'b0;
    i_start        = 1'b0;
    i_nai          = '0;
    i_base_p       = '0;
    i_base_x       = '0;
    i_rai          = '0;
    i_pattern_size = '0;
    i_byte_mask    = '0;
    i_wr_ready     = 1'b1;
    cfg_nai        = '0;
    cfg_base_p     = '0;
    cfg_base_x     = '0;
    cfg_rai        = '0;
    cfg_size       = '0;
    cfg_mask       = '0;
    exp_n          = 0;
    wr_count       = 0;
    value_errors   = 0;
    other_errors   = 0;
    hold_valid     = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;
    reset_and_address_run();
    pattern_size_sweep();
    back_pressure_stall();
    random_ready_runs();
    ignored_start_and_empty_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: wr_gen_top.sv
module wr_gen_top #(
  parameter int BUF_DEPTH  = 16,
  parameter int BUF_THRESH = 10
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 i_start,
  input  wr_gen_pkg::count_t   i_nai,
  input  wr_gen_pkg::pattern_t i_base_p,
  input  wr_gen_pkg::addr_t    i_base_x,
  input  wr_gen_pkg::incr_t    i_rai,
  input  wr_gen_pkg::psize_t   i_pattern_size,
  input  wr_gen_pkg::mask_t    i_byte_mask,
  input  logic                 i_wr_ready,
  output logic                 o_busy,
  output logic                 o_wr_valid,
  output wr_gen_pkg::addr_t    o_wr_addr,
  output wr_gen_pkg::line_t    o_wr_data,
  output wr_gen_pkg::mask_t    o_wr_strb
);

  logic almost_full;
  logic pop;
  logic accept;
  logic clear;

  // item links between the stages
  wr_item_if seq_if ();
  wr_item_if pipe_if ();
  wr_item_if buf_if ();

  // run control, throttled by the buffer fill level
  wr_sequencer u_seq (
    .clk(clk), .reset_n(reset_n), .i_start(i_start), .i_nai(i_nai),
    .i_base_p(i_base_p), .i_almost_full(almost_full), .i_accept(accept),
    .o_busy(o_busy), .o_clear(clear), .seq_if(seq_if.src)
  );

  wr_addr_pattern_pipe u_pipe (
    .clk(clk), .reset_n(reset_n), .i_base_x(i_base_x), .i_rai(i_rai),
    .i_pattern_size(i_pattern_size), .seq_if(seq_if.dst), .pipe_if(pipe_if.src)
  );

  wr_line_buffer #(.BUF_DEPTH(BUF_DEPTH), .BUF_THRESH(BUF_THRESH)) u_buf (
    .clk(clk), .reset_n(reset_n), .i_clear(clear), .i_pop(pop),
    .o_almost_full(almost_full), .pipe_if(pipe_if.dst), .buf_if(buf_if.src)
  );

  // the write port itself is driven from the buffer head
  wr_line_issue #(.BUF_DEPTH(BUF_DEPTH)) u_issue (
    .i_pattern_size(i_pattern_size), .i_byte_mask(i_byte_mask), .i_wr_ready(i_wr_ready),
    .o_pop(pop), .o_accept(accept), .o_wr_valid(o_wr_valid), .o_wr_addr(o_wr_addr),
    .o_wr_data(o_wr_data), .o_wr_strb(o_wr_strb), .buf_if(buf_if.dst)
  );

endmodule

// File: wr_line_issue.sv
module wr_line_issue #(
  parameter int BUF_DEPTH = 16
) (
  input  wr_gen_pkg::psize_t i_pattern_size,
  input  wr_gen_pkg::mask_t  i_byte_mask,
  input  logic               i_wr_ready,
  output logic               o_pop,
  output logic               o_accept,
  output logic               o_wr_valid,
  output wr_gen_pkg::addr_t  o_wr_addr,
  output wr_gen_pkg::line_t  o_wr_data,
  output wr_gen_pkg::mask_t  o_wr_strb,
  wr_item_if.dst             buf_if
);
  import wr_gen_pkg::*;

  line_t line_data;
  logic  wr_fire;

  // a shallower buffer cannot hold the items left in the pipe when the port stalls
  if (BUF_DEPTH < 4)
  begin : g_depth_check
    $error("write buffer needs at least four entries");
  end

  // repeat the pattern over the line, lane i takes pattern byte i mod size
  always_comb
  begin : expand_line
    logic [1:0] lane_sel;
    line_data = '0;
    for (int i = 0; i < LINE_BYTES; i++)
    begin
      case (i_pattern_size)
        3'd2:    lane_sel = 2'(i % 2);
        3'd4:    lane_sel = 2'(i % 4);
        // size 1 uses byte zero, other codes carry a zero pattern anyway
        default: lane_sel = 2'd0;
      endcase
      // lanes outside the byte mask stay zero
      if (i_byte_mask[i])
        line_data[i*8 +: 8] = buf_if.pattern[lane_sel*8 +: 8];
    end
  end

  // the head does not move until it is popped, which keeps the port stable while not ready
  assign o_wr_valid = buf_if.valid;
  assign o_wr_addr  = buf_if.addr;
  assign o_wr_data  = line_data;
  assign o_wr_strb  = i_byte_mask;

  // a write is taken in the cycle with valid and ready both high
  assign wr_fire  = buf_if.valid && i_wr_ready;
  assign o_pop    = wr_fire;
  assign o_accept = wr_fire;

endmodule

// File: wr_line_buffer.sv
module wr_line_buffer #(
  parameter int BUF_DEPTH  = 16,
  parameter int BUF_THRESH = 10
) (
  input  logic   clk,
  input  logic   reset_n,
  input  logic   i_clear,
  input  logic   i_pop,
  output logic   o_almost_full,
  wr_item_if.dst pipe_if,
  wr_item_if.src buf_if
);
  import wr_gen_pkg::*;

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  count_t     n_mem    [BUF_DEPTH];
  addr_t      addr_mem [BUF_DEPTH];
  pattern_t   pat_mem  [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             push;
  logic             pop;

  // pointers wrap at the last entry, so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // the pipe cannot be stalled, so every valid item is written
  assign push = pipe_if.valid;
  // a pop on an empty buffer is ignored
  assign pop  = i_pop && (fill != '0);

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop)
        fill <= fill + 1'b1;
      else if (pop && !push)
        fill <= fill - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      n_mem[wr_ptr]    <= pipe_if.n;
      addr_mem[wr_ptr] <= pipe_if.addr;
      pat_mem[wr_ptr]  <= pipe_if.pattern;
    end
  end

  // the head entry is shown whenever the buffer holds an item
  assign buf_if.valid   = (fill != '0);
  assign buf_if.n       = n_mem[rd_ptr];
  assign buf_if.addr    = addr_mem[rd_ptr];
  assign buf_if.pattern = pat_mem[rd_ptr];

  // the margin above the threshold absorbs the items still in flight in the pipe
  assign o_almost_full = (fill >= CNT_W'(BUF_THRESH));

endmodule

// File: wr_addr_pattern_pipe.sv
module wr_addr_pattern_pipe (
  input  logic                clk,
  input  logic                reset_n,
  input  wr_gen_pkg::addr_t   i_base_x,
  input  wr_gen_pkg::incr_t   i_rai,
  input  wr_gen_pkg::psize_t  i_pattern_size,
  wr_item_if.dst              seq_if,
  wr_item_if.src              pipe_if
);
  import wr_gen_pkg::*;

  logic     s1_valid;
  count_t   s1_n;
  addr_t    s1_offset;
  pattern_t s1_pattern;
  pattern_t cut_pattern;

  // keep the low 1, 2 or 4 bytes of P, any other size code gives a zero pattern
  always_comb
  begin
    case (i_pattern_size)
      3'd1:    cut_pattern = {24'd0, seq_if.pattern[7:0]};
      3'd2:    cut_pattern = {16'd0, seq_if.pattern[15:0]};
      3'd4:    cut_pattern = seq_if.pattern;
      default: cut_pattern = '0;
    endcase
  end

  // valid moves one stage per edge, so up to two items are in flight here
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      s1_valid      <= 1'b0;
      pipe_if.valid <= 1'b0;
    end
    else
    begin
      s1_valid      <= seq_if.valid;
      pipe_if.valid <= s1_valid;
    end
  end

  // stage one keeps N times RAI as a running sum, restarted by the item with N of zero
  always_ff @(posedge clk)
  begin
    if (seq_if.valid)
    begin
      s1_n       <= seq_if.n;
      s1_pattern <= cut_pattern;
      if (seq_if.n == '0)
        s1_offset <= '0;
      else
        s1_offset <= s1_offset + addr_t'(i_rai);
    end
  end

  // stage two adds the base address X to the offset
  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      pipe_if.n       <= s1_n;
      pipe_if.addr    <= i_base_x + s1_offset;
      pipe_if.pattern <= s1_pattern;
    end
  end

endmodule

// File: wr_sequencer.sv
module wr_sequencer (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 i_start,
  input  wr_gen_pkg::count_t   i_nai,
  input  wr_gen_pkg::pattern_t i_base_p,
  input  logic                 i_almost_full,
  input  logic                 i_accept,
  output logic                 o_busy,
  output logic                 o_clear,
  wr_item_if.src               seq_if
);
  import wr_gen_pkg::*;

  seq_state_t state;
  seq_state_t next_state;
  count_t     n_cnt;
  pattern_t   p_cnt;
  count_t     acc_cnt;
  logic       start_run;
  logic       emit;

  // a start is only taken when no run is in progress, so a strobe in mid-run is dropped
  assign start_run = i_start && ((state == SEQ_IDLE) || (state == SEQ_DONE));

  // one item per cycle until all NAI items are out, paused while the buffer is near full
  assign emit = (state == SEQ_RUN) && (n_cnt < i_nai) && !i_almost_full;

  // the buffer is emptied at the same edge that starts the run
  assign o_clear = start_run;

  // busy covers the issue phase and the wait for the last acceptance
  assign o_busy = (state == SEQ_RUN) || (state == SEQ_DRAIN);

  always_comb
  begin
    next_state = state;
    case (state)
      SEQ_IDLE:
      begin
        if (start_run)
          next_state = SEQ_RUN;
      end
      SEQ_RUN:
      begin
        // with NAI of zero this is true at once and the run ends without a write
        if (n_cnt >= i_nai)
          next_state = SEQ_DRAIN;
      end
      SEQ_DRAIN:
      begin
        if (acc_cnt == i_nai)
          next_state = SEQ_DONE;
      end
      SEQ_DONE:
      begin
        // done already counts as not busy, so a new start here is honoured
        if (start_run)
          next_state = SEQ_RUN;
        else
          next_state = SEQ_IDLE;
      end
      default:
        next_state = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state         <= SEQ_IDLE;
      n_cnt         <= '0;
      acc_cnt       <= '0;
      seq_if.valid  <= 1'b0;
    end
    else
    begin
      state        <= next_state;
      seq_if.valid <= emit;
      if (start_run)
        n_cnt <= '0;
      else if (emit)
        n_cnt <= n_cnt + 1'b1;
      // accepted writes are counted against NAI to know when the run has drained
      if (start_run)
        acc_cnt <= '0;
      else if (i_accept)
        acc_cnt <= acc_cnt + 1'b1;
    end
  end

  // P starts at the base pattern and steps by one with every item sent
  always_ff @(posedge clk)
  begin
    if (start_run)
      p_cnt <= i_base_p;
    else if (emit)
      p_cnt <= p_cnt + 1'b1;
    if (emit)
    begin
      seq_if.n       <= n_cnt;
      seq_if.pattern <= p_cnt;
    end
  end

  // the address is formed later in the pipe
  assign seq_if.addr = '0;

endmodule

// File: wr_item_if.sv
interface wr_item_if;
  import wr_gen_pkg::*;

  // high for exactly the one cycle in which an item is handed over
  logic     valid;
  // item index N within the run
  count_t   n;
  // write address, left at zero on the link out of the sequencer
  addr_t    addr;
  // raw or size-cut pattern, depending on the stage
  pattern_t pattern;

  // the producing stage drives every field
  modport src (
    output valid, n, addr, pattern
  );

  // the consuming stage has no way to stall the producer
  modport dst (
    input valid, n, addr, pattern
  );

endinterface

// File: wr_gen_pkg.sv
package wr_gen_pkg;

  // byte address of one cache line write
  typedef logic [51:0] addr_t;

  // raw pattern value before the size cut
  typedef logic [31:0] pattern_t;

  // item index N and the item count NAI share one width
  typedef logic [8:0] count_t;

  // address increment RAI between two items
  typedef logic [37:0] incr_t;

  // pattern size code, only 1, 2 and 4 select a non-zero pattern
  typedef logic [2:0] psize_t;

  // one 512-bit cache line of write data
  typedef logic [511:0] line_t;

  // one bit per byte of the line, used as byte mask and as write strobe
  typedef logic [63:0] mask_t;

  // number of byte lanes in a line
  localparam int LINE_BYTES = 64;

  // run states of the sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_RUN   = 2'd1,
    SEQ_DRAIN = 2'd2,
    SEQ_DONE  = 2'd3
  } seq_state_t;

endpackage
